//--- Makefile
# Verilator build and run of the SD card testbench, driven by sources.f
TOP       ?= sdCardTb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns
FAIL_MSG  ?= FAIL: see errors above

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$*

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sources.f
source/sdPkg.sv
source/sdIfs.sv
source/sdCmdReceiver.sv
source/sdCardCtrl.sv
source/sdByteLink.sv
source/sdBlockMem.sv
source/sdCardTop.sv
verif/tbClock.sv
verif/sdCardTb.sv

//--- verif/sdCardTb.sv
// testbench for the SD card slave that sends SPI commands and data on mosi
// and checks miso against a card model kept here, using random stimulus
`timescale 1ns/1ns
`default_nettype none

module sdCardTb;
   import sdPkg::*;

   localparam int RESP_TIMEOUT = 200;   // cycles per search on miso

   logic sclk;
   logic rstn;
   logic ncs;
   logic mosi;
   logic miso;

   byteT model [MEM_BYTES];   // expected card contents
   logic initFlag;
   logic appFlag;
   int   checks;
   int   valueErrors;
   int   protoErrors;

   tbClock tbClock_inst (
      .sclk (sclk),
      .rstn (rstn)
   );

   sdCardTop sdCardTop_inst (
      .sclk (sclk),
      .rstn (rstn),
      .ncs  (ncs),
      .mosi (mosi),
      .miso (miso)
   );

   task automatic checkLevel(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         valueErrors++;
         $display("FAILED miso (%s): got %h, expected %h", what, got, exp);
      end
   endtask

   task automatic checkR1(input string what, input byteT got, input byteT exp);
      checks++;
      if (got !== exp) begin
         valueErrors++;
         $display("FAILED miso R1 (%s): got %h, expected %h", what, got, exp);
      end
   endtask

   task automatic checkByte(input string what, input byteT got, input byteT exp);
      checks++;
      if (got !== exp) begin
         valueErrors++;
         $display("FAILED miso byte (%s): got %h, expected %h", what, got, exp);
      end
   endtask

   task automatic checkOcr(input string what, input ocrT got, input ocrT exp);
      checks++;
      if (got !== exp) begin
         valueErrors++;
         $display("FAILED miso OCR (%s): got %h, expected %h", what, got, exp);
      end
   endtask

   // drives mosi just after the edge and samples miso there too
   task automatic clockBit(input logic b, output logic s);
      @(posedge sclk);
      #1;
      mosi = b;
      s = miso;
   endtask

   task automatic shiftByte(input byteT tx, output byteT rx);
      logic s;
      for (int i = 7; i >= 0; i--) begin
         clockBit(tx[i], s);
         rx = {rx[6:0], s};
      end
   endtask

   task automatic readWord(output logic [31:0] w);
      byteT b;
      for (int i = 0; i < 4; i++) begin
         shiftByte(8'hFF, b);
         w = {w[23:0], b};
      end
   endtask

   task automatic sendCmd(input cmdIndexT idx, input argT arg);
      logic [47:0] frame;
      byteT        unused;
      frame = {2'b01, idx, arg, 7'($urandom), 1'b1};   // random crc that the card ignores
      shiftByte(8'hFF, unused);   // idle byte between commands
      for (int i = 0; i < 6; i++) begin
         shiftByte(frame[47 - 8 * i -: 8], unused);
      end
   endtask

   // response starts at the first 0 bit on miso
   task automatic findResp(output byteT r);
      logic s;
      int   n;
      r = 8'hFF;
      s = 1'b1;
      n = 0;
      while (s && n < RESP_TIMEOUT) begin
         clockBit(1'b1, s);
         n++;
      end
      if (s) begin
         protoErrors++;
         $display("no response from the card within %0d cycles", RESP_TIMEOUT);
      end else begin
         r = 8'h00;
         for (int i = 6; i >= 0; i--) begin
            clockBit(1'b1, s);
            r[i] = s;
         end
      end
   endtask

   task automatic findToken(output logic found);
      byteT sr;
      logic s;
      sr = 8'hFF;
      found = 1'b0;
      for (int n = 0; n < RESP_TIMEOUT && !found; n++) begin
         clockBit(1'b1, s);
         sr = {sr[6:0], s};
         found = (sr == TOKEN_START);
      end
   endtask

   // R1 from the response rules and the model's flags
   function automatic byteT expectR1(input cmdIndexT idx, input argT arg);
      byteT idle;
      idle = initFlag ? 8'h00 : R1_IDLE;
      if (appFlag) begin
         return (idx == cmdIndexT'(ACMD_OP_COND)) ? 8'h00 : (idle | R1_ILLEGAL);
      end
      case (idx)
         cmdIndexT'(CMD_GO_IDLE): return R1_IDLE;
         cmdIndexT'(CMD_SEND_IF_COND), cmdIndexT'(CMD_APP), cmdIndexT'(CMD_READ_OCR):
            return idle;
         cmdIndexT'(CMD_READ_SINGLE), cmdIndexT'(CMD_WRITE_SINGLE): begin
            if (!initFlag) return R1_IDLE | R1_ILLEGAL;
            return (arg >= NUM_BLOCKS) ? R1_ADDR_ERR : 8'h00;
         end
         default: return idle | R1_ILLEGAL;
      endcase
   endfunction

   function automatic logic isKnown(input cmdIndexT idx);
      return int'(idx) inside {CMD_GO_IDLE, CMD_SEND_IF_COND, CMD_READ_SINGLE,
                               CMD_WRITE_SINGLE, CMD_APP, CMD_READ_OCR};
   endfunction

   task automatic doCmd(input cmdIndexT idx, input argT arg, input string name);
      byteT exp;
      byteT r;
      exp = expectR1(idx, arg);
      sendCmd(idx, arg);
      findResp(r);
      checkR1(name, r, exp);
      if (appFlag && idx == cmdIndexT'(ACMD_OP_COND)) initFlag = 1'b1;
      if (!appFlag && idx == cmdIndexT'(CMD_GO_IDLE)) initFlag = 1'b0;
      appFlag = !appFlag && (idx == cmdIndexT'(CMD_APP));
   endtask

   task automatic ifCond(input logic [3:0] vhs);
      byteT        pat;
      logic [31:0] tail;
      pat = byteT'($urandom);
      doCmd(cmdIndexT'(CMD_SEND_IF_COND), {20'h0, vhs, pat}, "CMD8");
      readWord(tail);
      checkByte("CMD8 byte 1", tail[31:24], 8'h00);
      checkByte("CMD8 byte 2", tail[23:16], 8'h00);
      checkByte("CMD8 voltage", tail[15:8], (vhs == VHS_ACCEPT) ? 8'h01 : 8'h00);
      checkByte("CMD8 pattern", tail[7:0], pat);
   endtask

   task automatic writeBlock(input blockIdxT blk);
      byteT b;
      byteT r;
      logic s;
      int   busy;
      shiftByte(8'hFF, r);   // gap before the token
      shiftByte(TOKEN_START, r);
      for (int i = 0; i < BLOCK_BYTES; i++) begin
         b = byteT'($urandom);
         model[{blk, byteCntT'(i)}] = b;
         shiftByte(b, r);
      end
      shiftByte(byteT'($urandom), r);   // crc bytes
      shiftByte(byteT'($urandom), r);
      findResp(r);
      checkByte("data response", r, DATA_ACCEPTED);
      busy = 0;
      s = 1'b0;
      for (int n = 0; n < RESP_TIMEOUT && !s; n++) begin
         clockBit(1'b1, s);
         if (!s) busy++;
      end
      if (!s) begin
         protoErrors++;
         $display("write busy on block %0d did not end within %0d cycles", blk, RESP_TIMEOUT);
      end else if (busy != BUSY_BYTES * 8) begin
         protoErrors++;
         $display("write busy lasted %0d cycles instead of %0d", busy, BUSY_BYTES * 8);
      end
   endtask

   task automatic readBlock(input blockIdxT blk);
      byteT b;
      logic found;
      findToken(found);
      if (!found) begin
         protoErrors++;
         $display("no read token for block %0d within %0d cycles", blk, RESP_TIMEOUT);
      end else begin
         for (int i = 0; i < BLOCK_BYTES; i++) begin
            shiftByte(8'hFF, b);
            checkByte("read data", b, model[{blk, byteCntT'(i)}]);
         end
         shiftByte(8'hFF, b);
         checkByte("read crc high", b, 8'hAA);
         shiftByte(8'hFF, b);
         checkByte("read crc low", b, 8'hAA);
      end
   endtask

   initial begin
      logic        s;
      logic        found;
      logic [31:0] w;
      logic [3:0]  vhs;
      cmdIndexT    idx;
      blockIdxT    blk;
      void'($urandom(15));
      ncs = 1'b1;
      mosi = 1'b1;
      initFlag = 1'b0;
      appFlag = 1'b0;
      checks = 0;
      valueErrors = 0;
      protoErrors = 0;
      for (int i = 0; i < MEM_BYTES; i++) model[i] = byteT'(i) + 8'd3;
      for (int n = 0; n < 100 && rstn !== 1'b1; n++) @(posedge sclk);
      if (rstn !== 1'b1) begin
         protoErrors++;
         $display("reset was never released");
      end
      #1 ncs = 1'b0;

      // before initialization
      for (int i = 0; i < 16; i++) begin
         clockBit(1'b1, s);
         checkLevel("idle after reset", s, 1'b1);
      end
      doCmd(cmdIndexT'(CMD_READ_OCR), '0, "CMD58 uninitialized");
      readWord(w);
      checkOcr("uninitialized", w, OCR_BASE);
      doCmd(cmdIndexT'(CMD_READ_SINGLE), argT'($urandom_range(0, 7)), "CMD17 uninitialized");
      findToken(found);
      if (found) begin
         protoErrors++;
         $display("card sent a read token before initialization");
      end

      // CMD0 and CMD8 with accepted and rejected voltage
      doCmd(cmdIndexT'(CMD_GO_IDLE), '0, "CMD0");
      ifCond(VHS_ACCEPT);
      vhs = 4'($urandom_range(0, 14));
      if (vhs >= VHS_ACCEPT) vhs = vhs + 4'd1;
      ifCond(vhs);

      // initialization followed by illegal commands
      doCmd(cmdIndexT'(CMD_APP), '0, "CMD55");
      doCmd(cmdIndexT'(ACMD_OP_COND), 32'h4000_0000, "ACMD41");
      doCmd(cmdIndexT'(CMD_READ_OCR), '0, "CMD58 initialized");
      readWord(w);
      checkOcr("initialized", w, OCR_BASE + OCR_READY);
      for (int i = 0; i < 3; i++) begin
         idx = cmdIndexT'($urandom);
         if (idx == cmdIndexT'(ACMD_OP_COND)) idx = idx + 6'd1;
         doCmd(cmdIndexT'(CMD_APP), '0, "CMD55");
         doCmd(idx, argT'($urandom), "unsupported ACMD");
         idx = cmdIndexT'($urandom);
         if (isKnown(idx)) idx = idx + 6'd1;   // no two known indices are adjacent
         doCmd(idx, argT'($urandom), "unsupported CMD");
      end

      // random block writes and every block read back from a random start
      for (int i = 0; i < 4; i++) begin
         blk = blockIdxT'($urandom);
         doCmd(cmdIndexT'(CMD_WRITE_SINGLE), argT'(blk), "CMD24");
         writeBlock(blk);
      end
      blk = blockIdxT'($urandom);
      for (int i = 0; i < NUM_BLOCKS; i++) begin
         doCmd(cmdIndexT'(CMD_READ_SINGLE), argT'(blk), "CMD17");
         readBlock(blk);
         blk = blk + 3'd1;
      end

      // out of range block numbers
      doCmd(cmdIndexT'(CMD_READ_SINGLE), $urandom() | 32'h8, "CMD17 out of range");
      findToken(found);
      if (found) begin
         protoErrors++;
         $display("card sent a read token for an out of range block");
      end
      doCmd(cmdIndexT'(CMD_WRITE_SINGLE), $urandom() | 32'h8, "CMD24 out of range");
      // a card left hunting for a write token would not answer this
      doCmd(cmdIndexT'(CMD_READ_OCR), '0, "CMD58 after rejected write");
      readWord(w);
      checkOcr("after rejected write", w, OCR_BASE + OCR_READY);

      $display("checks %0d, value errors %0d, protocol errors %0d",
               checks, valueErrors, protoErrors);
      if (valueErrors + protoErrors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/tbClock.sv
// sclk generator with a 10 ns period, holds rstn low for the first 16 cycles
`timescale 1ns/1ns
`default_nettype none

module tbClock (
   output logic sclk,
   output logic rstn
);

   initial begin
      sclk = 1'b0;
      rstn = 1'b0;
      repeat (16) @(posedge sclk);
      #1 rstn = 1'b1;   // released just after an edge
   end

   always #5 sclk = ~sclk;

endmodule

`default_nettype wire

//--- source/sdCardTop.sv
// SPI-mode SD card slave of high capacity with 8 blocks of 512 bytes
// clocked by the host's sclk; instantiate as the DUT
`timescale 1ns/1ns
`default_nettype none

module sdCardTop (
   input  logic sclk,
   input  logic rstn,
   input  logic ncs,
   input  logic mosi,
   output logic miso
);

   sdCmdIf  cmdBus ();
   sdByteIf byteBus ();
   sdMemIf  memBus ();

   sdCmdReceiver sdCmdReceiver_inst (
      .sclk (sclk),
      .rstn (rstn),
      .ncs  (ncs),
      .mosi (mosi),
      .cmd  (cmdBus.sender)
   );

   sdCardCtrl sdCardCtrl_inst (
      .sclk (sclk),
      .rstn (rstn),
      .cmd  (cmdBus.receiver),
      .link (byteBus.controller),
      .mem  (memBus.master)
   );

   sdByteLink sdByteLink_inst (
      .sclk (sclk),
      .rstn (rstn),
      .mosi (mosi),
      .miso (miso),
      .link (byteBus.link)
   );

   sdBlockMem sdBlockMem_inst (
      .sclk (sclk),
      .mem  (memBus.memory)
   );

endmodule

`default_nettype wire

//--- source/sdBlockMem.sv
// 4 KiB card storage with synchronous write and registered read
// every byte starts as its address's low byte plus 3
`timescale 1ns/1ns
`default_nettype none

module sdBlockMem (
   input logic sclk,
   sdMemIf.memory mem
);
   import sdPkg::*;

   byteT storage [MEM_BYTES];

   initial begin
      for (int i = 0; i < MEM_BYTES; i++) begin
         storage[i] = byteT'(i) + 8'd3;
      end
   end

   always_ff @(posedge sclk) begin
      if (mem.wrEn) storage[mem.addr] <= mem.wrData;
      mem.rdData <= storage[mem.addr];   // old data on a write cycle
   end

endmodule

`default_nettype wire

//--- source/sdByteLink.sv
// byte-level link to the host that serializes bytes onto miso MSB first
// and frames mosi into bytes after the end of a start token
`timescale 1ns/1ns
`default_nettype none

module sdByteLink (
   input  logic sclk,
   input  logic rstn,
   input  logic mosi,
   output logic miso,
   sdByteIf.link link
);
   import sdPkg::*;

   byteT       txSr;
   logic [3:0] txCnt;     // bits left on the wire or 0 when idle
   byteT       rxSr;
   logic [2:0] rxCnt;
   logic       hunting;   // waiting for the 0 that ends the token

   assign link.txDone = (txCnt == 4'd1);
   assign link.rxData = rxSr;

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         miso <= 1'b1;
         txCnt <= '0;
      end else if (link.txLoad) begin
         miso <= link.txData[7];
         txCnt <= 4'd8;
      end else if (txCnt > 4'd1) begin
         miso <= txSr[7];
         txCnt <= txCnt - 4'd1;
      end else begin
         miso <= 1'b1;   // idle high
         txCnt <= '0;
      end
   end

   always_ff @(posedge sclk) begin
      if (link.txLoad) txSr <= {link.txData[6:0], 1'b1};
      else txSr <= {txSr[6:0], 1'b1};
   end

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         hunting <= 1'b0;
         rxCnt <= '0;
         link.rxValid <= 1'b0;
      end else begin
         link.rxValid <= 1'b0;
         if (link.rxHunt) begin
            hunting <= 1'b1;
            rxCnt <= '0;
         end else if (hunting) begin
            if (!mosi) hunting <= 1'b0;   // bytes start on the next bit
         end else if (link.rxActive) begin
            rxCnt <= rxCnt + 3'd1;
            if (rxCnt == 3'd7) link.rxValid <= 1'b1;
         end
      end
   end

   always_ff @(posedge sclk) begin
      if (!hunting && link.rxActive) rxSr <= {rxSr[6:0], mosi};
   end

endmodule

`default_nettype wire

//--- source/sdCardCtrl.sv
// command decoder and response/data sequencer of the card
// builds R1/R3/R7, streams read blocks out and takes write blocks into memory
`timescale 1ns/1ns
`default_nettype none

module sdCardCtrl (
   input logic sclk,
   input logic rstn,
   sdCmdIf.receiver cmd,
   sdByteIf.controller link,
   sdMemIf.master mem
);
   import sdPkg::*;

   ctrlStateT   state, stateNext;
   byteCntT     byteCnt, byteCntNext;
   logic [39:0] respSr, respSrNext;   // response bytes, MSB byte first
   blockIdxT    blkIdx;
   logic        initFlag, appFlag;
   logic        goRead, goWrite;

   // decode results for the frame on cmd
   byteT        r1Idle, r1Byte;
   logic [31:0] respTail;
   byteCntT     respLen;
   logic        decRead, decWrite, initNext, appNext;
   ocrT         ocrVal;

   assign ocrVal = initFlag ? (OCR_BASE | OCR_READY) : OCR_BASE;
   assign appNext = !appFlag && (cmd.cmdIndex == cmdIndexT'(CMD_APP));

   always_comb begin
      r1Idle = initFlag ? 8'h00 : R1_IDLE;
      r1Byte = r1Idle | R1_ILLEGAL;   // anything not matched below
      respTail = '0;
      respLen = 9'd1;
      decRead = 1'b0;
      decWrite = 1'b0;
      initNext = initFlag;
      if (appFlag) begin
         if (cmd.cmdIndex == cmdIndexT'(ACMD_OP_COND)) begin
            r1Byte = 8'h00;
            initNext = 1'b1;
         end
      end else begin
         case (cmd.cmdIndex)
            cmdIndexT'(CMD_GO_IDLE): begin
               r1Byte = R1_IDLE;
               initNext = 1'b0;
            end
            cmdIndexT'(CMD_SEND_IF_COND): begin
               r1Byte = r1Idle;
               respTail = {16'h0000, (cmd.cmdArg[11:8] == VHS_ACCEPT) ? 8'h01 : 8'h00,
                           cmd.cmdArg[7:0]};
               respLen = 9'd5;
            end
            cmdIndexT'(CMD_APP): r1Byte = r1Idle;
            cmdIndexT'(CMD_READ_OCR): begin
               r1Byte = r1Idle;
               respTail = ocrVal;
               respLen = 9'd5;
            end
            cmdIndexT'(CMD_READ_SINGLE), cmdIndexT'(CMD_WRITE_SINGLE): begin
               if (initFlag) begin
                  if (cmd.cmdArg >= argT'(NUM_BLOCKS)) begin
                     r1Byte = R1_ADDR_ERR;
                  end else begin
                     r1Byte = 8'h00;
                     decRead = (cmd.cmdIndex == cmdIndexT'(CMD_READ_SINGLE));
                     decWrite = (cmd.cmdIndex == cmdIndexT'(CMD_WRITE_SINGLE));
                  end
               end
            end
            default: ;
         endcase
      end
   end

   assign cmd.ready = (state == ST_IDLE);
   assign link.rxActive = (state == ST_WR_DATA) || (state == ST_WR_CRC);
   assign mem.addr = {blkIdx, byteCnt};
   assign mem.wrData = link.rxData;

   // loads land on txDone so the byte stream stays gapless
   always_comb begin
      stateNext = state;
      byteCntNext = byteCnt;
      respSrNext = respSr;
      link.txLoad = 1'b0;
      link.txData = 8'hFF;
      link.rxHunt = 1'b0;
      mem.wrEn = 1'b0;
      case (state)
         ST_IDLE: if (cmd.cmdValid) begin
            link.txLoad = 1'b1;   // filler byte
            respSrNext = {r1Byte, respTail};
            byteCntNext = respLen;
            stateNext = ST_RESP;
         end
         ST_RESP: if (link.txDone) begin
            if (byteCnt != '0) begin
               link.txLoad = 1'b1;
               link.txData = respSr[39:32];
               respSrNext = {respSr[31:0], 8'hFF};
               byteCntNext = byteCnt - 9'd1;
            end else if (goRead) begin
               link.txLoad = 1'b1;   // one 0xFF before the token
               stateNext = ST_RD_GAP;
            end else if (goWrite) begin
               link.rxHunt = 1'b1;
               byteCntNext = '0;
               stateNext = ST_WR_DATA;
            end else begin
               stateNext = ST_IDLE;
            end
         end
         ST_RD_GAP: if (link.txDone) begin
            link.txLoad = 1'b1;
            link.txData = TOKEN_START;
            byteCntNext = '0;   // first read address goes out here
            stateNext = ST_RD_DATA;
         end
         ST_RD_DATA: if (link.txDone) begin
            link.txLoad = 1'b1;
            link.txData = mem.rdData;
            byteCntNext = byteCnt + 9'd1;
            if (byteCnt == byteCntT'(BLOCK_BYTES - 1)) stateNext = ST_RD_CRC;
         end
         ST_RD_CRC: if (link.txDone) begin
            if (byteCnt == 9'd2) begin
               stateNext = ST_IDLE;
            end else begin
               link.txLoad = 1'b1;
               link.txData = byteCnt[0] ? CRC_STUCK[7:0] : CRC_STUCK[15:8];
               byteCntNext = byteCnt + 9'd1;
            end
         end
         ST_WR_DATA: if (link.rxValid) begin
            mem.wrEn = 1'b1;
            byteCntNext = byteCnt + 9'd1;
            if (byteCnt == byteCntT'(BLOCK_BYTES - 1)) stateNext = ST_WR_CRC;
         end
         ST_WR_CRC: if (link.rxValid) begin
            byteCntNext = byteCnt + 9'd1;
            if (byteCnt == 9'd1) begin
               link.txLoad = 1'b1;   // 0xFF ahead of the data response
               stateNext = ST_WR_GAP;
            end
         end
         ST_WR_GAP: if (link.txDone) begin
            link.txLoad = 1'b1;
            link.txData = DATA_ACCEPTED;
            byteCntNext = '0;
            stateNext = ST_WR_BUSY;
         end
         ST_WR_BUSY: if (link.txDone) begin
            if (byteCnt == byteCntT'(BUSY_BYTES)) begin
               stateNext = ST_IDLE;
            end else begin
               link.txLoad = 1'b1;
               link.txData = 8'h00;   // busy holds miso low
               byteCntNext = byteCnt + 9'd1;
            end
         end
         default: stateNext = ST_IDLE;
      endcase
   end

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         state <= ST_IDLE;
         byteCnt <= '0;
         initFlag <= 1'b0;
         appFlag <= 1'b0;
         goRead <= 1'b0;
         goWrite <= 1'b0;
      end else begin
         state <= stateNext;
         byteCnt <= byteCntNext;
         if (state == ST_IDLE && cmd.cmdValid) begin
            initFlag <= initNext;
            appFlag <= appNext;
            goRead <= decRead;
            goWrite <= decWrite;
         end
      end
   end

   always_ff @(posedge sclk) begin
      respSr <= respSrNext;
      if (state == ST_IDLE && cmd.cmdValid) blkIdx <= cmd.cmdArg[2:0];
   end

endmodule

`default_nettype wire

//--- source/sdCmdReceiver.sv
// hunts mosi for the start of a 48-bit command frame and shifts it in
// pulses cmdValid with index and argument once the stop bit is sampled
`timescale 1ns/1ns
`default_nettype none

module sdCmdReceiver (
   input logic sclk,
   input logic rstn,
   input logic ncs,
   input logic mosi,
   sdCmdIf.sender cmd
);

   typedef enum logic [1:0] {
      RX_WAIT_START,
      RX_WAIT_TX,
      RX_SHIFT
   } rxPhaseT;

   rxPhaseT     phase;
   logic [5:0]  bitCnt;    // 46 bits after the start and transmission bits
   logic [37:0] frameSr;   // index and argument only
   logic        hunting;

   // no new frame while the controller is busy or a pulse is going out
   assign hunting = cmd.ready && !cmd.cmdValid;

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         phase <= RX_WAIT_START;
         bitCnt <= '0;
         cmd.cmdValid <= 1'b0;
      end else begin
         cmd.cmdValid <= 1'b0;
         if (ncs) begin
            phase <= RX_WAIT_START;   // deselect aborts a partial frame
         end else begin
            case (phase)
               RX_WAIT_START: if (hunting && !mosi) phase <= RX_WAIT_TX;
               RX_WAIT_TX: if (mosi) begin
                  phase <= RX_SHIFT;
                  bitCnt <= '0;
               end
               RX_SHIFT: begin
                  bitCnt <= bitCnt + 6'd1;
                  if (bitCnt == 6'd45) begin   // stop bit
                     cmd.cmdValid <= 1'b1;
                     phase <= RX_WAIT_START;
                  end
               end
               default: phase <= RX_WAIT_START;
            endcase
         end
      end
   end

   // crc and stop bit fall past the end and are dropped
   always_ff @(posedge sclk) begin
      if (phase == RX_SHIFT && bitCnt < 6'd38) frameSr <= {frameSr[36:0], mosi};
   end

   assign cmd.cmdIndex = frameSr[37:32];
   assign cmd.cmdArg   = frameSr[31:0];

endmodule

`default_nettype wire

//--- source/sdIfs.sv
// interfaces between the card's internal blocks for commands, the byte link and memory
// instantiated once each in the card top
`timescale 1ns/1ns
`default_nettype none

interface sdCmdIf;
   import sdPkg::*;

   logic     cmdValid;   // one-cycle pulse per captured frame
   cmdIndexT cmdIndex;
   argT      cmdArg;
   logic     ready;      // high while the controller is idle and a new frame may start

   modport sender   (output cmdValid, cmdIndex, cmdArg, input ready);
   modport receiver (input cmdValid, cmdIndex, cmdArg, output ready);
endinterface

interface sdByteIf;
   import sdPkg::*;

   logic txLoad;
   byteT txData;
   logic txDone;     // last bit of the byte is on miso
   logic rxHunt;
   logic rxActive;
   logic rxValid;
   byteT rxData;

   modport controller (output txLoad, txData, rxHunt, rxActive,
                       input txDone, rxValid, rxData);
   modport link       (input txLoad, txData, rxHunt, rxActive,
                       output txDone, rxValid, rxData);
endinterface

interface sdMemIf;
   import sdPkg::*;

   memAddrT addr;
   byteT    wrData;
   logic    wrEn;
   byteT    rdData;   // one cycle after addr

   modport master (output addr, wrData, wrEn, input rdData);
   modport memory (input addr, wrData, wrEn, output rdData);
endinterface

`default_nettype wire

//--- source/sdPkg.sv
// shared types, command numbers, response codes and sizes of the SPI-mode SD card
// imported by the card modules and the interfaces that carry typed fields
`default_nettype none

package sdPkg;

   typedef logic [7:0]  byteT;      // one byte on the bus or in memory
   typedef logic [5:0]  cmdIndexT;
   typedef logic [31:0] argT;
   typedef logic [31:0] ocrT;
   typedef logic [11:0] memAddrT;   // byte address with the block number on top
   typedef logic [2:0]  blockIdxT;
   typedef logic [8:0]  byteCntT;   // byte position within a block

   // sizes
   localparam int unsigned BLOCK_BYTES = 512;
   localparam int unsigned NUM_BLOCKS  = 8;
   localparam int unsigned MEM_BYTES   = BLOCK_BYTES * NUM_BLOCKS;
   localparam int unsigned BUSY_BYTES  = 4;    // length of the write busy phase in bytes

   // command numbers
   localparam int unsigned CMD_GO_IDLE      = 0;
   localparam int unsigned CMD_SEND_IF_COND = 8;
   localparam int unsigned CMD_READ_SINGLE  = 17;
   localparam int unsigned CMD_WRITE_SINGLE = 24;
   localparam int unsigned CMD_APP          = 55;
   localparam int unsigned CMD_READ_OCR     = 58;
   localparam int unsigned ACMD_OP_COND     = 41;

   // R1 bits
   localparam byteT R1_IDLE     = 8'h01;
   localparam byteT R1_ILLEGAL  = 8'h04;
   localparam byteT R1_ADDR_ERR = 8'h20;

   localparam byteT        TOKEN_START   = 8'hFE;
   localparam byteT        DATA_ACCEPTED = 8'h05;
   localparam logic [15:0] CRC_STUCK     = 16'hAAAA;  // read data crc is not computed
   localparam ocrT         OCR_BASE      = 32'h00FF8000;  // 2.7 to 3.6 V window
   localparam ocrT         OCR_READY     = 32'hC0000000;  // power-up done and high capacity
   localparam logic [3:0]  VHS_ACCEPT    = 4'h1;

   // controller states
   typedef enum logic [3:0] {
      ST_IDLE,
      ST_RESP,      // filler byte followed by R1 and the R3/R7 tail
      ST_RD_GAP,
      ST_RD_DATA,
      ST_RD_CRC,
      ST_WR_DATA,
      ST_WR_CRC,
      ST_WR_GAP,
      ST_WR_BUSY
   } ctrlStateT;

endpackage

`default_nettype wire
